// File: design/eth_tx_pkg.sv
/* Ethernet transmit shared definitions */
package eth_tx_pkg;

	// Frame sequencing states
	typedef enum logic [2:0] {
		st_idle     = 3'd0,
		st_preamble = 3'd1,
		st_sfd      = 3'd2,
		st_payload  = 3'd3,
		st_fcs      = 3'd4,
		st_gap      = 3'd5
	} tx_state_e;

	// Local bus region, from lb_addr[23:20]
	typedef enum logic [3:0] {
		region_regs = 4'd0,
		region_buf  = 4'd1
	} lb_region_e;

	// Preamble and start of frame delimiter
	localparam int preamble_len = 7;
	localparam logic [7:0] preamble_byte = 8'h55;
	localparam logic [7:0] sfd_byte = 8'hD5;

	// Interframe gap in byte times
	localparam int ifg_len = 12;

	// Number of frame check bytes
	localparam int fcs_len = 4;

	// Reflected CRC-32 polynomial, LSB first
	localparam logic [31:0] crc_poly_rev = 32'hEDB88320;

endpackage

// File: design/tx_ifs.sv
/* Transmit control and CRC interfaces */

// Register block to frame FSM
interface tx_ctrl_if #(
	parameter int mac_aw = 10
) ();
	logic start;
	logic [mac_aw:0] frame_len;
	logic busy;
	logic done;

	modport regs (output start, output frame_len, input busy, input done);
	modport fsm (input start, input frame_len, output busy, output done);
endinterface

// Frame FSM to CRC generator
interface crc_if ();
	logic init;
	logic en;
	logic [7:0] data_byte;
	logic [31:0] crc;

	modport ctl (output init, output en, output data_byte, input crc);
	modport gen (input init, input en, input data_byte, output crc);
endinterface

// File: design/lb_regs.sv
/* Local bus registers and buffer write port */
module lb_regs #(
	parameter int mac_aw = 10
) (
	input  logic              tx_clk,
	input  logic              arst_n,
	input  logic [23:0]       lb_addr,
	input  logic [31:0]       lb_data_out,
	input  logic              lb_control_strobe,
	input  logic              lb_control_rd,
	output logic [31:0]       lb_data_in,
	output logic              lb_control_rd_valid,
	output logic              buf_we,
	output logic [mac_aw-1:0] buf_waddr,
	output logic [15:0]       buf_wdata,
	tx_ctrl_if.regs           ctrl
);

	eth_tx_pkg::lb_region_e region;
	logic [19:0] reg_addr;
	logic wr;
	logic rd;
	logic start_ok;
	logic [15:0] frame_cnt;
	logic [31:0] rd_mux;

	assign region = eth_tx_pkg::lb_region_e'(lb_addr[23:20]);
	assign reg_addr = lb_addr[19:0];
	assign wr = lb_control_strobe & ~lb_control_rd;
	assign rd = lb_control_strobe & lb_control_rd;

	// Frame buffer writes go straight through
	assign buf_we = wr && (region == eth_tx_pkg::region_buf);
	assign buf_waddr = lb_addr[mac_aw-1:0];
	assign buf_wdata = lb_data_out[15:0];

	// Ignore a start while a frame is in flight or for an empty frame
	assign start_ok = wr && (region == eth_tx_pkg::region_regs) && (reg_addr == 20'd0) &&
		!ctrl.busy && (lb_data_out[mac_aw:0] != '0);

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl.start <= 1'b0;
			ctrl.frame_len <= '0;
			frame_cnt <= '0;
			lb_control_rd_valid <= 1'b0;
		end else begin
			ctrl.start <= start_ok;
			if (start_ok)
				ctrl.frame_len <= lb_data_out[mac_aw:0];
			if (ctrl.done)
				frame_cnt <= frame_cnt + 16'd1;
			lb_control_rd_valid <= rd;
		end
	end

	// Read mux, buffer region has no read path
	always_comb begin
		rd_mux = '0;
		if (region == eth_tx_pkg::region_regs) begin
			case (reg_addr)
				20'd0: rd_mux = 32'({ctrl.busy, ctrl.frame_len});
				20'd1: rd_mux = {16'd0, frame_cnt};
				default: rd_mux = '0;
			endcase
		end
	end

	always_ff @(posedge tx_clk) begin
		if (rd)
			lb_data_in <= rd_mux;
	end

endmodule

// File: design/tx_buffer.sv
/* Transmit frame buffer */
module tx_buffer #(
	parameter int mac_aw = 10
) (
	input  logic              tx_clk,
	input  logic              we,
	input  logic [mac_aw-1:0] waddr,
	input  logic [15:0]       wdata,
	input  logic [mac_aw:0]   rd_addr,
	output logic [7:0]        rd_data
);

	localparam int depth = 2 ** mac_aw;

	logic [15:0] mem [0:depth-1];
	logic [15:0] rd_word;

	// Host side, one 16-bit word per write
	always_ff @(posedge tx_clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

	// Byte address bit 0 picks the half, low byte first
	assign rd_word = mem[rd_addr[mac_aw:1]];

	always_ff @(posedge tx_clk) begin
		if (rd_addr[0])
			rd_data <= rd_word[15:8];
		else
			rd_data <= rd_word[7:0];
	end

endmodule

// File: design/crc32_gen.sv
/* Byte-serial CRC-32 */
module crc32_gen (
	input  logic tx_clk,
	input  logic arst_n,
	crc_if.gen   c
);

	logic [31:0] crc_next;

	// One byte folded in, LSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc_in, input logic [7:0] d);
		logic [31:0] r;
		r = crc_in ^ {24'd0, d};
		for (int i = 0; i < 8; i++) begin
			if (r[0])
				r = (r >> 1) ^ eth_tx_pkg::crc_poly_rev;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	assign crc_next = crc_byte(c.crc, c.data_byte);

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			c.crc <= '1;
		end else if (c.init) begin
			c.crc <= '1;
		end else if (c.en) begin
			c.crc <= crc_next;
		end
	end

endmodule

// File: design/tx_frame_fsm.sv
/* GMII transmit frame sequencer */
module tx_frame_fsm #(
	parameter int mac_aw = 10
) (
	input  logic            tx_clk,
	input  logic            arst_n,
	tx_ctrl_if.fsm          ctrl,
	crc_if.ctl              c,
	output logic [mac_aw:0] rd_addr,
	input  logic [7:0]      rd_data,
	output logic [7:0]      txd,
	output logic            tx_en
);

	eth_tx_pkg::tx_state_e state;
	logic [mac_aw:0] cnt;
	logic last_byte;
	logic [31:0] fcs_word;
	logic [1:0] fcs_idx;

	// Payload counter tracks the byte currently on the wire
	assign last_byte = (cnt == ctrl.frame_len - 1'b1);

	// Inverted remainder, sent low byte first
	assign fcs_word = ~c.crc;
	assign fcs_idx = cnt[1:0] + 2'd1;

	// Covers the start cycle before the FSM leaves idle
	assign ctrl.busy = ctrl.start | (state != eth_tx_pkg::st_idle);
	assign ctrl.done = (state == eth_tx_pkg::st_gap) && (cnt == eth_tx_pkg::ifg_len - 1);

	// CRC sees each payload byte as it is loaded into txd
	assign c.init = (state == eth_tx_pkg::st_idle) && ctrl.start;
	assign c.en = (state == eth_tx_pkg::st_sfd) ||
		((state == eth_tx_pkg::st_payload) && !last_byte);
	assign c.data_byte = rd_data;

	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= eth_tx_pkg::st_idle;
			cnt <= '0;
			rd_addr <= '0;
			txd <= 8'd0;
			tx_en <= 1'b0;
		end else begin
			case (state)
				eth_tx_pkg::st_idle: begin
					cnt <= '0;
					rd_addr <= '0;
					if (ctrl.start) begin
						state <= eth_tx_pkg::st_preamble;
						txd <= eth_tx_pkg::preamble_byte;
						tx_en <= 1'b1;
					end
				end
				eth_tx_pkg::st_preamble: begin
					if (cnt == eth_tx_pkg::preamble_len - 1) begin
						state <= eth_tx_pkg::st_sfd;
						txd <= eth_tx_pkg::sfd_byte;
						// Byte 0 already requested, move on to byte 1
						rd_addr <= rd_addr + 1'b1;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
						txd <= eth_tx_pkg::preamble_byte;
					end
				end
				eth_tx_pkg::st_sfd: begin
					state <= eth_tx_pkg::st_payload;
					txd <= rd_data;
					rd_addr <= rd_addr + 1'b1;
					cnt <= '0;
				end
				eth_tx_pkg::st_payload: begin
					if (last_byte) begin
						state <= eth_tx_pkg::st_fcs;
						txd <= fcs_word[7:0];
						cnt <= '0;
					end else begin
						txd <= rd_data;
						rd_addr <= rd_addr + 1'b1;
						cnt <= cnt + 1'b1;
					end
				end
				eth_tx_pkg::st_fcs: begin
					if (cnt == eth_tx_pkg::fcs_len - 1) begin
						state <= eth_tx_pkg::st_gap;
						txd <= 8'd0;
						tx_en <= 1'b0;
						cnt <= '0;
					end else begin
						txd <= fcs_word[fcs_idx*8 +: 8];
						cnt <= cnt + 1'b1;
					end
				end
				eth_tx_pkg::st_gap: begin
					if (cnt == eth_tx_pkg::ifg_len - 1)
						state <= eth_tx_pkg::st_idle;
					else
						cnt <= cnt + 1'b1;
				end
				default: begin
					state <= eth_tx_pkg::st_idle;
					txd <= 8'd0;
					tx_en <= 1'b0;
				end
			endcase
		end
	end

endmodule

// File: design/status_timer.sv
/* Heartbeat, PHY reset and activity LED */
module status_timer #(
	parameter int hb_w = 27,
	parameter int phy_rst_bit = 21,
	parameter int act_w = 22
) (
	input  logic       tx_clk,
	input  logic       arst_n,
	input  logic       clk_locked,
	input  logic       tx_en,
	input  logic       busy,
	output logic       phy_rstn,
	output logic [3:0] led
);

	logic [hb_w-1:0] heartbeat;
	logic [act_w-1:0] act_cnt;
	logic act_on;

	// Free running
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n)
			heartbeat <= '0;
		else
			heartbeat <= heartbeat + 1'b1;
	end

	// PHY held in reset until the heartbeat bit comes up, lost lock wins
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n)
			phy_rstn <= 1'b0;
		else if (!clk_locked)
			phy_rstn <= 1'b0;
		else if (heartbeat[phy_rst_bit])
			phy_rstn <= 1'b1;
	end

	// Stretch tx_en so short frames are visible
	always_ff @(posedge tx_clk or negedge arst_n) begin
		if (!arst_n) begin
			act_cnt <= '0;
			act_on <= 1'b0;
		end else if (tx_en) begin
			act_cnt <= '1;
			act_on <= 1'b1;
		end else if (act_on) begin
			act_cnt <= act_cnt - 1'b1;
			if (act_cnt == '0)
				act_on <= 1'b0;
		end
	end

	// led[2] would be receive activity
	assign led = {tx_en | act_on, 1'b0, heartbeat[hb_w-1], busy};

endmodule

// File: design/hw_tx_top.sv
/* Ethernet transmit test target */
module hw_tx_top #(
	parameter int mac_aw = 10,
	parameter int hb_w = 27,
	parameter int phy_rst_bit = 21,
	parameter int act_w = 22
) (
	input  logic        tx_clk,
	input  logic        arst_n,
	// Local bus
	input  logic [23:0] lb_addr,
	input  logic [31:0] lb_data_out,
	input  logic        lb_control_strobe,
	input  logic        lb_control_rd,
	output logic [31:0] lb_data_in,
	output logic        lb_control_rd_valid,
	// GMII transmit
	output logic [7:0]  txd,
	output logic        tx_en,
	output logic        tx_er,
	output logic        tx_mac_done,
	// Board status
	input  logic        clk_locked,
	output logic        phy_rstn,
	output logic [3:0]  led
);

	logic buf_we;
	logic [mac_aw-1:0] buf_waddr;
	logic [15:0] buf_wdata;
	logic [mac_aw:0] rd_addr;
	logic [7:0] rd_data;

	tx_ctrl_if #(.mac_aw(mac_aw)) ctrl_if ();
	crc_if crc_bus ();

	lb_regs #(.mac_aw(mac_aw)) i_regs (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.lb_addr(lb_addr), .lb_data_out(lb_data_out),
		.lb_control_strobe(lb_control_strobe), .lb_control_rd(lb_control_rd),
		.lb_data_in(lb_data_in), .lb_control_rd_valid(lb_control_rd_valid),
		.buf_we(buf_we), .buf_waddr(buf_waddr), .buf_wdata(buf_wdata),
		.ctrl(ctrl_if.regs)
	);

	tx_buffer #(.mac_aw(mac_aw)) i_buffer (
		.tx_clk(tx_clk),
		.we(buf_we), .waddr(buf_waddr), .wdata(buf_wdata),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	crc32_gen i_crc (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.c(crc_bus.gen)
	);

	tx_frame_fsm #(.mac_aw(mac_aw)) i_fsm (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.ctrl(ctrl_if.fsm), .c(crc_bus.ctl),
		.rd_addr(rd_addr), .rd_data(rd_data),
		.txd(txd), .tx_en(tx_en)
	);

	status_timer #(.hb_w(hb_w), .phy_rst_bit(phy_rst_bit), .act_w(act_w)) i_timer (
		.tx_clk(tx_clk), .arst_n(arst_n),
		.clk_locked(clk_locked), .tx_en(tx_en), .busy(ctrl_if.busy),
		.phy_rstn(phy_rstn), .led(led)
	);

	// No error signalling on transmit
	assign tx_er = 1'b0;
	assign tx_mac_done = ctrl_if.done;

endmodule

// File: verif/tb_frame_model.sv
/* Transmit frame reference model */
package tb_frame_model;

	// xorshift32 step
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Ethernet CRC-32, one bit at a time, LSB of the byte first
	function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
		logic [31:0] c;
		logic fb;
		int i;
		c = crc;
		for (i = 0; i < 8; i++) begin
			fb = c[0] ^ b[i];
			c = c >> 1;
			if (fb)
				c = c ^ 32'hEDB88320;
		end
		return c;
	endfunction

	// Payload byte k out of its 16-bit buffer word, low byte first
	function automatic logic [7:0] payload_byte(input logic [15:0] w, input int k);
		if (k % 2 == 1)
			return w[15:8];
		return w[7:0];
	endfunction

	// Expected GMII byte at position idx of a frame
	function automatic logic [7:0] frame_byte(input int idx, input int len,
		input logic [7:0] pay, input logic [31:0] fcs);
		if (idx < 7)
			return 8'h55;
		if (idx == 7)
			return 8'hD5;
		if (idx < 8 + len)
			return pay;
		return fcs[(idx - 8 - len) * 8 +: 8];
	endfunction

endpackage

// File: verif/tb_hw_tx.sv
/* Transmit target testbench */
module tb_hw_tx;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int mac_aw = 6;
	localparam int hb_w = 10;
	localparam int phy_rst_bit = 8;
	localparam int act_w = 4;
	localparam int num_frames = 15;
	localparam int max_cycles = 20 * (8 + 128 + 4 + 12 + 40) + 2000;

	logic tx_clk = 1'b0;
	logic arst_n;
	logic [23:0] lb_addr;
	logic [31:0] lb_data_out;
	logic lb_control_strobe;
	logic lb_control_rd;
	logic [31:0] lb_data_in;
	logic lb_control_rd_valid;
	logic [7:0] txd;
	logic tx_en;
	logic tx_er;
	logic tx_mac_done;
	logic clk_locked;
	logic phy_rstn;
	logic [3:0] led;

	int cyc = 0;
	int value_errs = 0;
	int other_errs = 0;
	logic [31:0] rng;
	logic [15:0] model_mem [0:2**mac_aw-1];
	logic [7:0] exp_frame [0:255];
	int exp_total = 0;
	int model_count = 0;
	int frames_seen = 0;
	int done_seen = 0;
	int cap_idx = 0;
	bit in_frame = 1'b0;
	int wr0_cyc = -10;
	int fall_cyc = -1000;
	int busy_left = 0;
	bit busy_now = 1'b0;
	int hb_ticks = 0;

	hw_tx_top #(
		.mac_aw(mac_aw), .hb_w(hb_w), .phy_rst_bit(phy_rst_bit), .act_w(act_w)
	) i_dut (.*);

	always #10 tx_clk = ~tx_clk;

	always @(posedge tx_clk)
		cyc <= cyc + 1;

	// Cycles since reset release, top heartbeat bit drives led[1]
	always @(posedge tx_clk) begin
		if (!arst_n)
			hb_ticks <= 0;
		else
			hb_ticks <= hb_ticks + 1;
	end

	// Run limit
	always @(posedge tx_clk) begin
		if (cyc >= max_cycles) begin
			$display("Run stopped after %0d cycles without finishing", cyc);
			$display("Errors: %0d value, %0d other", value_errs, other_errs + 1);
			$display("Something failed");
			$finish;
		end
	end

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		other_errs++;
		$display("Error at cycle %0d: %s", cyc, msg);
	endtask

	// Bus write, strobe stays up so writes can run back to back
	task automatic bus_write(input logic [23:0] addr, input logic [31:0] data);
		@(posedge tx_clk);
		lb_addr <= addr;
		lb_data_out <= data;
		lb_control_rd <= 1'b0;
		lb_control_strobe <= 1'b1;
	endtask

	task automatic bus_idle();
		@(posedge tx_clk);
		lb_control_strobe <= 1'b0;
	endtask

	// Data comes back one cycle after the strobe
	task automatic bus_read(input logic [23:0] addr, output logic [31:0] data);
		@(posedge tx_clk);
		lb_addr <= addr;
		lb_control_rd <= 1'b1;
		lb_control_strobe <= 1'b1;
		@(posedge tx_clk);
		lb_control_strobe <= 1'b0;
		lb_control_rd <= 1'b0;
		@(negedge tx_clk);
		check_bit("lb_control_rd_valid", lb_control_rd_valid, 1'b1);
		data = lb_data_in;
	endtask

	task automatic run_frame(input bit poke_busy);
		int len;
		int k;
		logic [31:0] crc;
		logic [31:0] rd;
		logic [7:0] pay;
		rng = tb_frame_model::xorshift32(rng);
		len = 1 + int'(rng % 32'd127);
		for (k = 0; k < (len + 1) / 2; k++) begin
			rng = tb_frame_model::xorshift32(rng);
			model_mem[k] = rng[15:0];
			bus_write(24'h100000 + 24'(k), {16'd0, rng[15:0]});
		end
		crc = '1;
		for (k = 0; k < len; k++)
			crc = tb_frame_model::crc_step(crc, tb_frame_model::payload_byte(model_mem[k / 2], k));
		exp_total = 12 + len;
		for (k = 0; k < exp_total; k++) begin
			pay = 8'h00;
			if (k >= 8 && k < 8 + len)
				pay = tb_frame_model::payload_byte(model_mem[(k - 8) / 2], k - 8);
			exp_frame[k] = tb_frame_model::frame_byte(k, len, pay, ~crc);
		end
		bus_write(24'h000000, 32'(len));
		bus_read(24'h000000, rd);
		check_word("register 0 during frame", rd, 32'((1 << (mac_aw + 1)) | len));
		// Second start while busy must be dropped
		if (poke_busy) begin
			bus_write(24'h000000, 32'd5);
			bus_idle();
		end
		do
			@(negedge tx_clk);
		while (!tx_mac_done);
		model_count++;
		bus_read(24'h000001, rd);
		check_word("register 1 frame count", rd, 32'(model_count));
		check_word("tx_mac_done pulses", 32'(done_seen), 32'(model_count));
	endtask

	// Frame capture and LED watch
	always @(negedge tx_clk) begin
		if (arst_n) begin
			// Busy spans the start cycle, the frame on the wire and the gap
			busy_now = busy_left > 0;
			check_bit("led[0]", led[0], busy_now);
			check_bit("tx_mac_done", tx_mac_done, busy_left == 1);
			if (busy_now)
				busy_left--;
			if (lb_control_strobe && !lb_control_rd && lb_addr == 24'h000000) begin
				wr0_cyc = cyc;
				if (!busy_now && lb_data_out[mac_aw:0] != '0)
					busy_left = 1 + 8 + int'(lb_data_out[mac_aw:0]) + 4 + 12;
			end
			if (tx_en) begin
				if (!in_frame) begin
					in_frame = 1'b1;
					cap_idx = 0;
					frames_seen++;
					if (cyc != wr0_cyc + 2)
						report_error($sformatf("tx_en rose %0d cycles after the start write",
							cyc - wr0_cyc));
				end
				if (cap_idx < exp_total)
					check_byte("txd", txd, exp_frame[cap_idx]);
				else if (cap_idx == exp_total)
					report_error("tx_en stayed high past the end of the frame");
				cap_idx++;
				check_bit("led[3]", led[3], 1'b1);
			end else begin
				if (in_frame) begin
					in_frame = 1'b0;
					fall_cyc = cyc;
					if (cap_idx != exp_total)
						report_error($sformatf("tx_en was high for %0d cycles instead of %0d",
							cap_idx, exp_total));
				end
				check_bit("led[3]", led[3], (cyc - fall_cyc) < 2 ** act_w);
			end
			if (tx_mac_done)
				done_seen++;
			check_bit("led[2]", led[2], 1'b0);
			check_bit("led[1]", led[1], hb_ticks[hb_w - 1]);
			check_bit("tx_er", tx_er, 1'b0);
		end
	end

	initial begin
		int f;
		int n;
		int rel_cyc;
		logic [31:0] rd;
		arst_n = 1'b0;
		lb_addr = '0;
		lb_data_out = '0;
		lb_control_strobe = 1'b0;
		lb_control_rd = 1'b0;
		clk_locked = 1'b1;
		rng = 32'hd5c8_7ab3;
		repeat (2) @(posedge tx_clk);
		arst_n <= 1'b1;
		@(negedge tx_clk);
		rel_cyc = cyc;
		check_bit("tx_en", tx_en, 1'b0);
		check_bit("tx_mac_done", tx_mac_done, 1'b0);
		check_bit("phy_rstn", phy_rstn, 1'b0);
		check_bit("lb_control_rd_valid", lb_control_rd_valid, 1'b0);
		check_byte("txd", txd, 8'h00);

		// PHY reset release follows heartbeat bit
		while (!phy_rstn)
			@(negedge tx_clk);
		check_word("phy_rstn release delay", 32'(cyc - rel_cyc), 32'(2 ** phy_rst_bit + 1));

		for (f = 0; f < num_frames; f++)
			run_frame(f == 4);

		// Empty frame start is ignored
		bus_write(24'h000000, 32'd0);
		bus_idle();
		repeat (40) @(negedge tx_clk);
		check_word("frames sent", 32'(frames_seen), 32'(model_count));
		check_word("tx_mac_done pulses", 32'(done_seen), 32'(model_count));
		bus_read(24'h000001, rd);
		check_word("register 1 frame count", rd, 32'(model_count));
		bus_read(24'h000000, rd);
		check_bit("register 0 busy", rd[mac_aw + 1], 1'b0);
		bus_read(24'h000002, rd);
		check_word("register 2", rd, 32'd0);

		// Lost lock pulls the PHY back into reset
		@(posedge tx_clk);
		clk_locked <= 1'b0;
		@(posedge tx_clk);
		@(negedge tx_clk);
		check_bit("phy_rstn", phy_rstn, 1'b0);
		repeat (3) @(posedge tx_clk);
		clk_locked <= 1'b1;
		n = 0;
		while (!phy_rstn && n < 2 ** hb_w + 2) begin
			@(negedge tx_clk);
			n++;
		end
		if (!phy_rstn)
			report_error("phy_rstn did not rise within one heartbeat period after lock returned");

		repeat (20) @(negedge tx_clk);
		$display("Errors: %0d value, %0d other", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: files.f
design/eth_tx_pkg.sv
design/tx_ifs.sv
design/lb_regs.sv
design/tx_buffer.sv
design/crc32_gen.sv
design/tx_frame_fsm.sv
design/status_timer.sv
design/hw_tx_top.sv
verif/tb_frame_model.sv
verif/tb_hw_tx.sv
